//--- design/tlb_cfg.svh
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// entry count, index width must follow it
`define TLB_NUM         16
`define TLB_IDX_W       4

// tag fields
`define TLB_VPPN_W      19
`define TLB_ASID_W      10
`define TLB_HUGE_LO_W   9

// descriptor fields, attr packs {plv, mat, d, v}
`define TLB_PPN_W       20
`define TLB_PLV_W       2
`define TLB_MAT_W       2
`define TLB_ATTR_W      6

// page size codes
`define TLB_PS_W        6
`define TLB_PS_4K       12
`define TLB_PS_4M       21

`define TLB_INVOP_W     5

`endif

//--- design/tlb_pkg.sv
`default_nettype none

`include "tlb_cfg.svh"

package tlb_pkg;

    typedef logic [`TLB_VPPN_W-1:0] vppn_t;
    typedef logic [`TLB_ASID_W-1:0] asid_t;
    typedef logic [`TLB_PPN_W-1:0]  ppn_t;
    typedef logic [`TLB_PS_W-1:0]   ps_t;
    typedef logic [`TLB_IDX_W-1:0]  tlb_idx_t;
    typedef logic [`TLB_PLV_W-1:0]  plv_t;
    typedef logic [`TLB_MAT_W-1:0]  mat_t;

    // invtlb opcodes, codes 7 and up are no-ops
    typedef enum logic [`TLB_INVOP_W-1:0] {
        INV_ALL       = 5'd0,
        INV_ALL_ALT   = 5'd1,
        INV_GLOBAL    = 5'd2,
        INV_NONGLOBAL = 5'd3,
        INV_ASID      = 5'd4,
        INV_ASID_VA   = 5'd5,
        INV_GA_VA     = 5'd6
    } invtlb_op_e;

endpackage

`default_nettype wire

//--- design/tlb_match.sv
`default_nettype none
`timescale 1ns/10ps

`include "tlb_cfg.svh"

module tlb_match #(
    parameter int NUM = `TLB_NUM
) (
    input  wire tlb_pkg::vppn_t         key_vppn,
    input  wire tlb_pkg::asid_t         key_asid,
    input  wire [NUM-1:0]               ent_e,
    input  wire [NUM-1:0]               ent_huge,
    input  wire [NUM-1:0]               ent_g,
    input  wire [NUM*`TLB_VPPN_W-1:0]   ent_vppn,
    input  wire [NUM*`TLB_ASID_W-1:0]   ent_asid,
    output logic                        found,
    output tlb_pkg::tlb_idx_t           index
);

    import tlb_pkg::*;

    localparam int VW = `TLB_VPPN_W;
    localparam int AW = `TLB_ASID_W;
    localparam int LO = `TLB_HUGE_LO_W;

    logic [NUM-1:0] hit;

    // one comparator per entry
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            hit[i] = ent_e[i]
                && (key_vppn[VW-1:LO] == ent_vppn[i*VW+LO +: VW-LO])
                && (ent_huge[i] || (key_vppn[LO-1:0] == ent_vppn[i*VW +: LO]))
                && (ent_g[i] || (key_asid == ent_asid[i*AW +: AW]));
        end
    end

    assign found = |hit;

    // lowest index wins, scan downward so the last hit kept is the lowest
    always_comb begin
        index = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                index = tlb_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/tlb_inv_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

`include "tlb_cfg.svh"

module tlb_inv_ctrl #(
    parameter int NUM = `TLB_NUM
) (
    input  wire tlb_pkg::invtlb_op_e    op,
    input  wire tlb_pkg::asid_t         inv_asid,
    input  wire tlb_pkg::vppn_t         inv_vppn,
    input  wire [NUM-1:0]               ent_g,
    input  wire [NUM*`TLB_ASID_W-1:0]   ent_asid,
    input  wire [NUM*`TLB_VPPN_W-1:0]   ent_vppn,
    output logic [NUM-1:0]              inv_mask
);

    import tlb_pkg::*;

    localparam int VW = `TLB_VPPN_W;
    localparam int AW = `TLB_ASID_W;

    logic [NUM-1:0] asid_eq;
    logic [NUM-1:0] vppn_eq;

    // full vppn compare, page size not considered
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            asid_eq[i] = (ent_asid[i*AW +: AW] == inv_asid);
            vppn_eq[i] = (ent_vppn[i*VW +: VW] == inv_vppn);
        end
    end

    always_comb begin
        case (op)
            INV_ALL, INV_ALL_ALT: begin
                inv_mask = '1;
            end
            INV_GLOBAL: begin
                inv_mask = ent_g;
            end
            INV_NONGLOBAL: begin
                inv_mask = ~ent_g;
            end
            INV_ASID: begin
                inv_mask = ~ent_g & asid_eq;
            end
            INV_ASID_VA: begin
                inv_mask = ~ent_g & asid_eq & vppn_eq;
            end
            INV_GA_VA: begin
                inv_mask = (ent_g | asid_eq) & vppn_eq;
            end
            default: begin
                inv_mask = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/tlb_entry_array.sv
`default_nettype none
`timescale 1ns/10ps

`include "tlb_cfg.svh"

module tlb_entry_array #(
    parameter int NUM = `TLB_NUM
) (
    input  wire                         clk,
    input  wire                         rst,
    // write port
    input  wire                         we,
    input  wire tlb_pkg::tlb_idx_t      w_index,
    input  wire                         w_e,
    input  wire tlb_pkg::vppn_t         w_vppn,
    input  wire tlb_pkg::ps_t           w_ps,
    input  wire tlb_pkg::asid_t         w_asid,
    input  wire                         w_g,
    input  wire tlb_pkg::ppn_t          w_ppn0,
    input  wire tlb_pkg::plv_t          w_plv0,
    input  wire tlb_pkg::mat_t          w_mat0,
    input  wire                         w_d0,
    input  wire                         w_v0,
    input  wire tlb_pkg::ppn_t          w_ppn1,
    input  wire tlb_pkg::plv_t          w_plv1,
    input  wire tlb_pkg::mat_t          w_mat1,
    input  wire                         w_d1,
    input  wire                         w_v1,
    // invalidate
    input  wire                         invtlb_valid,
    input  wire [NUM-1:0]               inv_mask,
    // read port
    input  wire tlb_pkg::tlb_idx_t      r_index,
    output logic                        r_e,
    output tlb_pkg::vppn_t              r_vppn,
    output tlb_pkg::ps_t                r_ps,
    output tlb_pkg::asid_t              r_asid,
    output logic                        r_g,
    output tlb_pkg::ppn_t               r_ppn0,
    output tlb_pkg::plv_t               r_plv0,
    output tlb_pkg::mat_t               r_mat0,
    output logic                        r_d0,
    output logic                        r_v0,
    output tlb_pkg::ppn_t               r_ppn1,
    output tlb_pkg::plv_t               r_plv1,
    output tlb_pkg::mat_t               r_mat1,
    output logic                        r_d1,
    output logic                        r_v1,
    // flattened entry fields for the matchers
    output wire [NUM-1:0]               ent_e,
    output wire [NUM-1:0]               ent_huge,
    output wire [NUM-1:0]               ent_g,
    output wire [NUM*`TLB_VPPN_W-1:0]   ent_vppn,
    output wire [NUM*`TLB_ASID_W-1:0]   ent_asid,
    output wire [NUM*`TLB_PPN_W-1:0]    ent_ppn0,
    output wire [NUM*`TLB_PPN_W-1:0]    ent_ppn1,
    output wire [NUM*`TLB_ATTR_W-1:0]   ent_attr0,
    output wire [NUM*`TLB_ATTR_W-1:0]   ent_attr1
);

    import tlb_pkg::*;

    localparam int VW = `TLB_VPPN_W;
    localparam int AW = `TLB_ASID_W;
    localparam int PW = `TLB_PPN_W;
    localparam int TW = `TLB_ATTR_W;

    logic [NUM-1:0] e_q;
    logic [NUM-1:0] huge_q;
    logic [NUM-1:0] g_q;
    vppn_t          vppn_q  [NUM];
    asid_t          asid_q  [NUM];
    ppn_t           ppn0_q  [NUM];
    ppn_t           ppn1_q  [NUM];
    logic [TW-1:0]  attr0_q [NUM];
    logic [TW-1:0]  attr1_q [NUM];

    // kill mask first, a same-cycle write then overrides its own entry
    always_ff @(posedge clk) begin
        if (rst) begin
            e_q <= '0;
        end else begin
            if (invtlb_valid) begin
                e_q <= e_q & ~inv_mask;
            end
            if (we) begin
                e_q[w_index] <= w_e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            huge_q[w_index]  <= (w_ps == ps_t'(`TLB_PS_4M));
            g_q[w_index]     <= w_g;
            vppn_q[w_index]  <= w_vppn;
            asid_q[w_index]  <= w_asid;
            ppn0_q[w_index]  <= w_ppn0;
            ppn1_q[w_index]  <= w_ppn1;
            attr0_q[w_index] <= {w_plv0, w_mat0, w_d0, w_v0};
            attr1_q[w_index] <= {w_plv1, w_mat1, w_d1, w_v1};
        end
    end

    assign ent_e    = e_q;
    assign ent_huge = huge_q;
    assign ent_g    = g_q;

    for (genvar i = 0; i < NUM; i++) begin : g_flat
        assign ent_vppn[i*VW +: VW]  = vppn_q[i];
        assign ent_asid[i*AW +: AW]  = asid_q[i];
        assign ent_ppn0[i*PW +: PW]  = ppn0_q[i];
        assign ent_ppn1[i*PW +: PW]  = ppn1_q[i];
        assign ent_attr0[i*TW +: TW] = attr0_q[i];
        assign ent_attr1[i*TW +: TW] = attr1_q[i];
    end

    // read port
    assign r_e    = e_q[r_index];
    assign r_vppn = vppn_q[r_index];
    assign r_ps   = huge_q[r_index] ? ps_t'(`TLB_PS_4M) : ps_t'(`TLB_PS_4K);
    assign r_asid = asid_q[r_index];
    assign r_g    = g_q[r_index];
    assign r_ppn0 = ppn0_q[r_index];
    assign r_ppn1 = ppn1_q[r_index];

    assign {r_plv0, r_mat0, r_d0, r_v0} = attr0_q[r_index];
    assign {r_plv1, r_mat1, r_d1, r_v1} = attr1_q[r_index];

endmodule

`default_nettype wire

//--- design/tlb_translate.sv
`default_nettype none
`timescale 1ns/10ps

`include "tlb_cfg.svh"

module tlb_translate #(
    parameter int NUM = `TLB_NUM
) (
    input  wire tlb_pkg::vppn_t         vppn,
    input  wire                         va_bit12,
    input  wire tlb_pkg::asid_t         asid,
    input  wire [NUM-1:0]               ent_e,
    input  wire [NUM-1:0]               ent_huge,
    input  wire [NUM-1:0]               ent_g,
    input  wire [NUM*`TLB_VPPN_W-1:0]   ent_vppn,
    input  wire [NUM*`TLB_ASID_W-1:0]   ent_asid,
    input  wire [NUM*`TLB_PPN_W-1:0]    ent_ppn0,
    input  wire [NUM*`TLB_PPN_W-1:0]    ent_ppn1,
    input  wire [NUM*`TLB_ATTR_W-1:0]   ent_attr0,
    input  wire [NUM*`TLB_ATTR_W-1:0]   ent_attr1,
    output logic                        found,
    output tlb_pkg::tlb_idx_t           index,
    output tlb_pkg::ppn_t               ppn,
    output tlb_pkg::ps_t                ps,
    output tlb_pkg::plv_t               plv,
    output tlb_pkg::mat_t               mat,
    output logic                        d,
    output logic                        v
);

    import tlb_pkg::*;

    localparam int PW = `TLB_PPN_W;
    localparam int TW = `TLB_ATTR_W;

    logic          hit_huge;
    logic          odd;
    logic [TW-1:0] sel_attr;

    tlb_match #(.NUM(NUM)) u_match (
        .key_vppn (vppn),
        .key_asid (asid),
        .ent_e    (ent_e),
        .ent_huge (ent_huge),
        .ent_g    (ent_g),
        .ent_vppn (ent_vppn),
        .ent_asid (ent_asid),
        .found    (found),
        .index    (index)
    );

    assign hit_huge = ent_huge[index];

    // 4MB pair splits at vppn bit 8, 4KB pair at va bit 12
    assign odd = hit_huge ? vppn[`TLB_HUGE_LO_W-1] : va_bit12;

    assign ppn      = odd ? ent_ppn1[index*PW +: PW] : ent_ppn0[index*PW +: PW];
    assign sel_attr = odd ? ent_attr1[index*TW +: TW] : ent_attr0[index*TW +: TW];
    assign ps       = hit_huge ? ps_t'(`TLB_PS_4M) : ps_t'(`TLB_PS_4K);

    assign {plv, mat, d, v} = sel_attr;

endmodule

`default_nettype wire

//--- design/tlb.sv
`default_nettype none
`timescale 1ns/10ps

`include "tlb_cfg.svh"

module tlb #(
    parameter int NUM = `TLB_NUM
) (
    input  wire                         clk,
    input  wire                         rst,
    // fetch translation
    input  wire tlb_pkg::vppn_t         s0_vppn,
    input  wire                         s0_va_bit12,
    input  wire tlb_pkg::asid_t         s0_asid,
    output logic                        s0_found,
    output tlb_pkg::tlb_idx_t           s0_index,
    output tlb_pkg::ppn_t               s0_ppn,
    output tlb_pkg::ps_t                s0_ps,
    output tlb_pkg::plv_t               s0_plv,
    output tlb_pkg::mat_t               s0_mat,
    output logic                        s0_d,
    output logic                        s0_v,
    // tlbsrch
    input  wire tlb_pkg::vppn_t         tlbsrch_vppn,
    input  wire tlb_pkg::asid_t         tlbsrch_asid,
    output logic                        tlbsrch_found,
    output tlb_pkg::tlb_idx_t           tlbsrch_index,
    // invtlb
    input  wire                         invtlb_valid,
    input  wire [`TLB_INVOP_W-1:0]      invtlb_op,
    input  wire tlb_pkg::asid_t         invtlb_asid,
    input  wire tlb_pkg::vppn_t         invtlb_va,
    // write port
    input  wire                         we,
    input  wire tlb_pkg::tlb_idx_t      w_index,
    input  wire                         w_e,
    input  wire tlb_pkg::vppn_t         w_vppn,
    input  wire tlb_pkg::ps_t           w_ps,
    input  wire tlb_pkg::asid_t         w_asid,
    input  wire                         w_g,
    input  wire tlb_pkg::ppn_t          w_ppn0,
    input  wire tlb_pkg::plv_t          w_plv0,
    input  wire tlb_pkg::mat_t          w_mat0,
    input  wire                         w_d0,
    input  wire                         w_v0,
    input  wire tlb_pkg::ppn_t          w_ppn1,
    input  wire tlb_pkg::plv_t          w_plv1,
    input  wire tlb_pkg::mat_t          w_mat1,
    input  wire                         w_d1,
    input  wire                         w_v1,
    // read port
    input  wire tlb_pkg::tlb_idx_t      r_index,
    output logic                        r_e,
    output tlb_pkg::vppn_t              r_vppn,
    output tlb_pkg::ps_t                r_ps,
    output tlb_pkg::asid_t              r_asid,
    output logic                        r_g,
    output tlb_pkg::ppn_t               r_ppn0,
    output tlb_pkg::plv_t               r_plv0,
    output tlb_pkg::mat_t               r_mat0,
    output logic                        r_d0,
    output logic                        r_v0,
    output tlb_pkg::ppn_t               r_ppn1,
    output tlb_pkg::plv_t               r_plv1,
    output tlb_pkg::mat_t               r_mat1,
    output logic                        r_d1,
    output logic                        r_v1
);

    import tlb_pkg::*;

    wire [NUM-1:0]              ent_e;
    wire [NUM-1:0]              ent_huge;
    wire [NUM-1:0]              ent_g;
    wire [NUM*`TLB_VPPN_W-1:0]  ent_vppn;
    wire [NUM*`TLB_ASID_W-1:0]  ent_asid;
    wire [NUM*`TLB_PPN_W-1:0]   ent_ppn0;
    wire [NUM*`TLB_PPN_W-1:0]   ent_ppn1;
    wire [NUM*`TLB_ATTR_W-1:0]  ent_attr0;
    wire [NUM*`TLB_ATTR_W-1:0]  ent_attr1;
    wire [NUM-1:0]              inv_mask;

    tlb_entry_array #(.NUM(NUM)) u_array (
        .clk          (clk),
        .rst          (rst),
        .we           (we),
        .w_index      (w_index),
        .w_e          (w_e),
        .w_vppn       (w_vppn),
        .w_ps         (w_ps),
        .w_asid       (w_asid),
        .w_g          (w_g),
        .w_ppn0       (w_ppn0),
        .w_plv0       (w_plv0),
        .w_mat0       (w_mat0),
        .w_d0         (w_d0),
        .w_v0         (w_v0),
        .w_ppn1       (w_ppn1),
        .w_plv1       (w_plv1),
        .w_mat1       (w_mat1),
        .w_d1         (w_d1),
        .w_v1         (w_v1),
        .invtlb_valid (invtlb_valid),
        .inv_mask     (inv_mask),
        .r_index      (r_index),
        .r_e          (r_e),
        .r_vppn       (r_vppn),
        .r_ps         (r_ps),
        .r_asid       (r_asid),
        .r_g          (r_g),
        .r_ppn0       (r_ppn0),
        .r_plv0       (r_plv0),
        .r_mat0       (r_mat0),
        .r_d0         (r_d0),
        .r_v0         (r_v0),
        .r_ppn1       (r_ppn1),
        .r_plv1       (r_plv1),
        .r_mat1       (r_mat1),
        .r_d1         (r_d1),
        .r_v1         (r_v1),
        .ent_e        (ent_e),
        .ent_huge     (ent_huge),
        .ent_g        (ent_g),
        .ent_vppn     (ent_vppn),
        .ent_asid     (ent_asid),
        .ent_ppn0     (ent_ppn0),
        .ent_ppn1     (ent_ppn1),
        .ent_attr0    (ent_attr0),
        .ent_attr1    (ent_attr1)
    );

    // raw opcode from the core, unlisted codes fall to the no-op branch
    tlb_inv_ctrl #(.NUM(NUM)) u_inv (
        .op       (invtlb_op_e'(invtlb_op)),
        .inv_asid (invtlb_asid),
        .inv_vppn (invtlb_va),
        .ent_g    (ent_g),
        .ent_asid (ent_asid),
        .ent_vppn (ent_vppn),
        .inv_mask (inv_mask)
    );

    tlb_translate #(.NUM(NUM)) u_s0 (
        .vppn      (s0_vppn),
        .va_bit12  (s0_va_bit12),
        .asid      (s0_asid),
        .ent_e     (ent_e),
        .ent_huge  (ent_huge),
        .ent_g     (ent_g),
        .ent_vppn  (ent_vppn),
        .ent_asid  (ent_asid),
        .ent_ppn0  (ent_ppn0),
        .ent_ppn1  (ent_ppn1),
        .ent_attr0 (ent_attr0),
        .ent_attr1 (ent_attr1),
        .found     (s0_found),
        .index     (s0_index),
        .ppn       (s0_ppn),
        .ps        (s0_ps),
        .plv       (s0_plv),
        .mat       (s0_mat),
        .d         (s0_d),
        .v         (s0_v)
    );

    // tlbsrch needs the index only
    tlb_match #(.NUM(NUM)) u_srch (
        .key_vppn (tlbsrch_vppn),
        .key_asid (tlbsrch_asid),
        .ent_e    (ent_e),
        .ent_huge (ent_huge),
        .ent_g    (ent_g),
        .ent_vppn (ent_vppn),
        .ent_asid (ent_asid),
        .found    (tlbsrch_found),
        .index    (tlbsrch_index)
    );

endmodule

`default_nettype wire

//--- verification/tb_tlb.sv
`default_nettype none
`timescale 1ns/10ps

`include "tlb_cfg.svh"

module tb_tlb;

    import tlb_pkg::*;

    localparam int NUM          = `TLB_NUM;
    localparam int CLK_PERIOD   = 20;
    localparam int SETTLE       = 5;
    localparam int RESET_CYCLES = 4;
    // reset, read, 4k, 4m, eight invalidate rounds, collision test
    localparam int TEST_CYCLES  = 24 + 32 + 16 + 8 + 8 * 33 + 36;
    localparam int MARGIN       = 100;

    localparam logic [18:0] V1    = 19'h12345;
    localparam logic [18:0] V2    = 19'h2ab01;
    localparam logic [18:0] V3    = 19'h5c0aa;
    localparam logic [9:0]  ASID_A = 10'h011;
    localparam logic [9:0]  ASID_B = 10'h022;

    logic clk;
    logic rst;
    logic [18:0] s0_vppn;
    logic s0_va_bit12;
    logic [9:0] s0_asid;
    logic s0_found;
    logic [3:0] s0_index;
    logic [19:0] s0_ppn;
    logic [5:0] s0_ps;
    logic [1:0] s0_plv;
    logic [1:0] s0_mat;
    logic s0_d;
    logic s0_v;
    logic [18:0] tlbsrch_vppn;
    logic [9:0] tlbsrch_asid;
    logic tlbsrch_found;
    logic [3:0] tlbsrch_index;
    logic invtlb_valid;
    logic [4:0] invtlb_op;
    logic [9:0] invtlb_asid;
    logic [18:0] invtlb_va;
    logic we;
    logic [3:0] w_index;
    logic w_e;
    logic [18:0] w_vppn;
    logic [5:0] w_ps;
    logic [9:0] w_asid;
    logic w_g;
    logic [19:0] w_ppn0;
    logic [1:0] w_plv0;
    logic [1:0] w_mat0;
    logic w_d0;
    logic w_v0;
    logic [19:0] w_ppn1;
    logic [1:0] w_plv1;
    logic [1:0] w_mat1;
    logic w_d1;
    logic w_v1;
    logic [3:0] r_index;
    logic r_e;
    logic [18:0] r_vppn;
    logic [5:0] r_ps;
    logic [9:0] r_asid;
    logic r_g;
    logic [19:0] r_ppn0;
    logic [1:0] r_plv0;
    logic [1:0] r_mat0;
    logic r_d0;
    logic r_v0;
    logic [19:0] r_ppn1;
    logic [1:0] r_plv1;
    logic [1:0] r_mat1;
    logic r_d1;
    logic r_v1;

    // shadow of the entry array
    // attr packs {plv, mat, d, v}
    logic        m_e    [NUM];
    logic        m_g    [NUM];
    logic        m_huge [NUM];
    logic [18:0] m_vppn [NUM];
    logic [9:0]  m_asid [NUM];
    logic [19:0] m_ppn0 [NUM];
    logic [19:0] m_ppn1 [NUM];
    logic [5:0]  m_attr0 [NUM];
    logic [5:0]  m_attr1 [NUM];

    integer seed = 32'hb79ff61b;
    int test_errs;
    int total_errs;
    int tests_run;
    int tests_bad;

    tlb dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: simulation ran past its cycle budget");
        $display("Regression failed");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, act);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errs != 0) begin
            tests_bad++;
            $display("test %s: FAIL, %0d errors", name, test_errs);
        end else begin
            $display("test %s: ok", name);
        end
        test_errs = 0;
    endtask

    // expected kill condition of each invalidate opcode
    function automatic logic kills(input int op, input int i, input logic [9:0] asid,
                                   input logic [18:0] va);
        logic a_eq;
        logic v_eq;
        a_eq = (m_asid[i] == asid);
        v_eq = (m_vppn[i] == va);
        case (op)
            0, 1: kills = 1'b1;
            2: kills = m_g[i];
            3: kills = !m_g[i];
            4: kills = !m_g[i] && a_eq;
            5: kills = !m_g[i] && a_eq && v_eq;
            6: kills = (m_g[i] || a_eq) && v_eq;
            default: kills = 1'b0;
        endcase
    endfunction

    task automatic set_write(input int idx, input logic e, input logic [18:0] vppn,
                             input logic [5:0] ps, input logic [9:0] asid, input logic g);
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        we = 1'b1;
        w_index = idx[3:0];
        w_e = e;
        w_vppn = vppn;
        w_ps = ps;
        w_asid = asid;
        w_g = g;
        w_ppn0 = r0[19:0];
        {w_plv0, w_mat0, w_d0, w_v0} = r0[31:26];
        w_ppn1 = r1[19:0];
        {w_plv1, w_mat1, w_d1, w_v1} = r1[31:26];
        m_e[idx] = e;
        m_g[idx] = g;
        m_huge[idx] = (ps == `TLB_PS_4M);
        m_vppn[idx] = vppn;
        m_asid[idx] = asid;
        m_ppn0[idx] = r0[19:0];
        m_attr0[idx] = r0[31:26];
        m_ppn1[idx] = r1[19:0];
        m_attr1[idx] = r1[31:26];
    endtask

    // kill uses the old contents so it must precede a same-cycle set_write
    task automatic set_inv(input int op, input logic [9:0] asid, input logic [18:0] va);
        invtlb_valid = 1'b1;
        invtlb_op = op[4:0];
        invtlb_asid = asid;
        invtlb_va = va;
        for (int i = 0; i < NUM; i++) begin
            if (kills(op, i, asid, va)) begin
                m_e[i] = 1'b0;
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        we = 1'b0;
        invtlb_valid = 1'b0;
    endtask

    task automatic check_e_all(input string tag);
        for (int i = 0; i < NUM; i++) begin
            r_index = i[3:0];
            #(SETTLE);
            check_val($sformatf("r_e[%0d] %s", i, tag), m_e[i], r_e);
            @(negedge clk);
        end
    endtask

    task automatic check_read(input int idx);
        r_index = idx[3:0];
        #(SETTLE);
        check_val("r_e", m_e[idx], r_e);
        check_val("r_vppn", m_vppn[idx], r_vppn);
        check_val("r_ps", m_huge[idx] ? `TLB_PS_4M : `TLB_PS_4K, r_ps);
        check_val("r_asid", m_asid[idx], r_asid);
        check_val("r_g", m_g[idx], r_g);
        check_val("r_ppn0", m_ppn0[idx], r_ppn0);
        check_val("r_plv0/mat0/d0/v0", m_attr0[idx], {r_plv0, r_mat0, r_d0, r_v0});
        check_val("r_ppn1", m_ppn1[idx], r_ppn1);
        check_val("r_plv1/mat1/d1/v1", m_attr1[idx], {r_plv1, r_mat1, r_d1, r_v1});
        @(negedge clk);
    endtask

    // drives s0 and tlbsrch with one key
    task automatic check_xlate(input logic [18:0] vppn, input logic bit12, input logic [9:0] asid,
                               input logic exp_found, input int exp_idx);
        logic odd;
        s0_vppn = vppn;
        s0_va_bit12 = bit12;
        s0_asid = asid;
        tlbsrch_vppn = vppn;
        tlbsrch_asid = asid;
        #(SETTLE);
        check_val("s0_found", exp_found, s0_found);
        check_val("s0_index", exp_idx, s0_index);
        check_val("tlbsrch_found", exp_found, tlbsrch_found);
        check_val("tlbsrch_index", exp_idx, tlbsrch_index);
        if (exp_found) begin
            odd = m_huge[exp_idx] ? vppn[8] : bit12;
            check_val("s0_ppn", odd ? m_ppn1[exp_idx] : m_ppn0[exp_idx], s0_ppn);
            check_val("s0_plv/mat/d/v", odd ? m_attr1[exp_idx] : m_attr0[exp_idx],
                      {s0_plv, s0_mat, s0_d, s0_v});
            check_val("s0_ps", m_huge[exp_idx] ? `TLB_PS_4M : `TLB_PS_4K, s0_ps);
        end
        @(negedge clk);
    endtask

    // new tlbsrch key while s0 holds its previous key
    task automatic check_srch(input logic [18:0] vppn, input logic [9:0] asid,
                              input logic exp_found, input int exp_idx);
        tlbsrch_vppn = vppn;
        tlbsrch_asid = asid;
        #(SETTLE);
        check_val("tlbsrch_found", exp_found, tlbsrch_found);
        check_val("tlbsrch_index", exp_idx, tlbsrch_index);
        @(negedge clk);
    endtask

    task automatic test_reset();
        logic [31:0] r;
        for (int i = 0; i < NUM; i++) begin
            m_e[i] = 1'b0;
        end
        check_e_all("after reset");
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            check_xlate(r[18:0], r[19], r[29:20], 1'b0, 0);
        end
        report_test("reset");
    endtask

    task automatic test_write_read();
        logic [31:0] r;
        logic [31:0] r2;
        logic [5:0] ps;
        for (int i = 0; i < NUM; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            ps = (r[1:0] == 2'd0) ? 6'd21 : ((r[1:0] == 2'd1) ? 6'd12 : r[7:2]);
            set_write(i, r[8], r2[18:0], ps, r2[28:19], r[9]);
            step();
        end
        for (int i = 0; i < NUM; i++) begin
            check_read(i);
        end
        report_test("write_read");
    endtask

    task automatic test_xlate_4k();
        set_inv(0, ASID_A, V1);
        step();
        set_write(3, 1'b1, V1, 6'd12, ASID_A, 1'b0);
        step();
        check_xlate(V1, 1'b0, ASID_A, 1'b1, 3);
        check_xlate(V1, 1'b1, ASID_A, 1'b1, 3);
        check_xlate(V1 ^ 19'h1, 1'b0, ASID_A, 1'b0, 0);
        check_xlate(V1, 1'b0, ASID_B, 1'b0, 0);
        set_write(7, 1'b1, V2, 6'd12, ASID_A, 1'b1);
        step();
        check_xlate(V2, 1'b1, ASID_B, 1'b1, 7);
        // duplicates above and below an existing hit
        set_write(9, 1'b1, V1, 6'd12, ASID_A, 1'b0);
        step();
        set_write(2, 1'b1, V2, 6'd12, ASID_B, 1'b0);
        step();
        check_xlate(V1, 1'b1, ASID_A, 1'b1, 3);
        check_xlate(V2, 1'b0, ASID_B, 1'b1, 2);
        check_srch(V1, ASID_A, 1'b1, 3);
        report_test("xlate_4k");
    endtask

    task automatic test_xlate_4m();
        set_write(11, 1'b1, V3, 6'd21, ASID_A, 1'b0);
        step();
        check_xlate({V3[18:9], 9'h0ff}, 1'b1, ASID_A, 1'b1, 11);
        check_xlate({V3[18:9], 9'h123}, 1'b0, ASID_A, 1'b1, 11);
        check_xlate({V3[18:9] ^ 10'h001, 9'h000}, 1'b0, ASID_A, 1'b0, 0);
        report_test("xlate_4m");
    endtask

    task automatic test_invalidate();
        logic [31:0] r;
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < NUM; i++) begin
                r = $random(seed);
                set_write(i, 1'b1, r[2] ? V1 : V2, r[3] ? 6'd21 : 6'd12,
                          r[1] ? ASID_A : ASID_B, r[0]);
                step();
            end
            set_inv(op, ASID_A, V1);
            step();
            check_e_all($sformatf("op %0d", op));
        end
        report_test("invalidate");
    endtask

    task automatic test_write_vs_inv();
        for (int i = 0; i < NUM; i++) begin
            set_write(i, 1'b1, V1, 6'd12, ASID_A, 1'b0);
            step();
        end
        set_inv(4, ASID_A, V1);
        set_write(6, 1'b1, V2, 6'd12, ASID_B, 1'b0);
        step();
        check_e_all("write with invalidate");
        check_read(6);
        check_xlate(V2, 1'b0, ASID_B, 1'b1, 6);
        // invalidated entries keep matching tags but must miss
        check_xlate(V1, 1'b0, ASID_A, 1'b0, 0);
        report_test("write_vs_inv");
    endtask

    initial begin
        test_errs = 0;
        total_errs = 0;
        tests_run = 0;
        tests_bad = 0;
        rst = 1'b1;
        s0_vppn = '0;
        s0_va_bit12 = 1'b0;
        s0_asid = '0;
        tlbsrch_vppn = '0;
        tlbsrch_asid = '0;
        invtlb_valid = 1'b0;
        invtlb_op = '0;
        invtlb_asid = '0;
        invtlb_va = '0;
        we = 1'b0;
        w_index = '0;
        w_e = 1'b0;
        w_vppn = '0;
        w_ps = '0;
        w_asid = '0;
        w_g = 1'b0;
        w_ppn0 = '0;
        {w_plv0, w_mat0, w_d0, w_v0} = '0;
        w_ppn1 = '0;
        {w_plv1, w_mat1, w_d1, w_v1} = '0;
        r_index = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_write_read();
        test_xlate_4k();
        test_xlate_4m();
        test_invalidate();
        test_write_vs_inv();

        $display("tests run: %0d, tests with errors: %0d, failed checks: %0d",
                 tests_run, tests_bad, total_errs);
        if (total_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/tlb_pkg.sv
design/tlb_match.sv
design/tlb_inv_ctrl.sv
design/tlb_entry_array.sv
design/tlb_translate.sv
design/tlb.sv
verification/tb_tlb.sv
